// File: source/cnn_types_pkg.sv
/*
 * Data types of the CNN dot-product engine
 * Byte, product and vector widths shared by all stages
 */
package cnn_types_pkg;

    localparam int DATA_W              = 8;     // Weights, line values and results
    localparam int VEC_LEN             = 16;    // Elements per operand vector
    localparam int GROUP_LEN           = 8;     // Elements summed into one partial sum
    localparam int NUM_GROUPS          = 4;
    localparam int DEFAULT_NUM_RESULTS = 16;

    typedef logic [DATA_W-1:0]          data_t;
    typedef logic [2*DATA_W-1:0]        prod_t;     // Full unsigned 8x8 product
    typedef logic [$clog2(VEC_LEN)-1:0] addr_t;

    // Element i sits at bits [i*DATA_W +: DATA_W]
    typedef logic [VEC_LEN*DATA_W-1:0] data_vec_t;

    // Product i sits at bits [i*2*DATA_W +: 2*DATA_W]
    typedef logic [VEC_LEN*2*DATA_W-1:0] prod_vec_t;

    // Partial sum g sits at bits [g*DATA_W +: DATA_W]
    //   g0 low bytes of elements 0-7, g1 low bytes of 8-15
    //   g2 high bytes of elements 0-7, g3 high bytes of 8-15
    typedef logic [NUM_GROUPS*DATA_W-1:0] psum_vec_t;

endpackage

// File: source/cnn_ctrl_pkg.sv
/*
 * Control types of the CNN dot-product engine
 * FSM encodings and the packed structs carried between stages
 */
package cnn_ctrl_pkg;

    import cnn_types_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_WEIGHTS,
        LOAD_LINE,
        COMPUTE         // Single cycle, fires the pipeline
    } load_state_t;

    typedef enum logic {
        SER_IDLE,
        SER_EMIT
    } ser_state_t;

    // Serial byte with its strobe, for both inputs and the result stream
    typedef struct packed {
        logic  valid;
        data_t data;
    } byte_stream_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        data_t data;
    } buf_write_t;

    typedef struct packed {
        logic      valid;
        prod_vec_t prod;
    } prod_stage_t;

    typedef struct packed {
        logic      valid;
        psum_vec_t psum;
    } psum_stage_t;

endpackage

// File: source/load_controller.sv
`timescale 1ns/1ps
/*
 * Load controller
 * Takes 16 weight bytes then 16 line bytes into the operand buffers, then pulses compute
 */
module load_controller
    import cnn_types_pkg::*;
    import cnn_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start_i,
    input  byte_stream_t weight_in_i,
    input  byte_stream_t line_in_i,
    output buf_write_t   weight_wr_o,
    output buf_write_t   line_wr_o,
    output logic         compute_o
);

    load_state_t state_q;
    addr_t       elem_cnt_q;     // Element index, shared by both load phases
    logic        weight_en_q;
    logic        line_en_q;
    logic        compute_q;
    addr_t       wr_addr_q;
    data_t       wr_data_q;      // Only one stream is taken per cycle

    logic weight_take;
    logic line_take;
    logic last_elem;

    // Bytes outside their own phase are dropped here
    assign weight_take = (state_q == LOAD_WEIGHTS) && weight_in_i.valid;
    assign line_take   = (state_q == LOAD_LINE) && line_in_i.valid;
    assign last_elem   = (elem_cnt_q == addr_t'(VEC_LEN - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q     <= IDLE;
            elem_cnt_q  <= '0;
            weight_en_q <= 1'b0;
            line_en_q   <= 1'b0;
            compute_q   <= 1'b0;
        end else begin
            weight_en_q <= weight_take;
            line_en_q   <= line_take;
            compute_q   <= 1'b0;
            if (weight_take || line_take) begin
                elem_cnt_q <= elem_cnt_q + 1'b1;    // Wraps to 0 after element 15
            end

            case (state_q)
                IDLE: begin
                    elem_cnt_q <= '0;
                    if (start_i) begin
                        state_q <= LOAD_WEIGHTS;
                    end
                end
                LOAD_WEIGHTS: begin
                    if (weight_take && last_elem) begin
                        state_q <= LOAD_LINE;
                    end
                end
                LOAD_LINE: begin
                    if (line_take && last_elem) begin
                        state_q <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    compute_q <= 1'b1;      // Last line byte is in the buffer by now
                    state_q   <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Write payload, qualified by the enable bits above
    always_ff @(posedge clk) begin
        if (weight_take || line_take) begin
            wr_addr_q <= elem_cnt_q;
            wr_data_q <= line_take ? line_in_i.data : weight_in_i.data;
        end
    end

    assign weight_wr_o = '{en: weight_en_q, addr: wr_addr_q, data: wr_data_q};
    assign line_wr_o   = '{en: line_en_q, addr: wr_addr_q, data: wr_data_q};
    assign compute_o   = compute_q;

endmodule

// File: source/operand_buffer.sv
`timescale 1ns/1ps
/*
 * Operand buffer
 * 16-byte register file, written one byte at a time, all entries read in parallel
 */
module operand_buffer
    import cnn_types_pkg::*;
    import cnn_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  buf_write_t wr_i,
    output data_vec_t  data_o
);

    data_t mem_q [VEC_LEN];

    // Entries start at zero so a partial load computes on known data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < VEC_LEN; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_i.en) begin
            mem_q[wr_i.addr] <= wr_i.data;
        end
    end

    // Flatten, element 0 in the low byte
    always_comb begin
        for (int i = 0; i < VEC_LEN; i++) begin
            data_o[i*DATA_W +: DATA_W] = mem_q[i];
        end
    end

endmodule

// File: source/mac_array.sv
`timescale 1ns/1ps
/*
 * Multiplier array
 * Sixteen unsigned 8x8 multipliers with one register stage
 */
module mac_array
    import cnn_types_pkg::*;
    import cnn_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        compute_i,
    input  data_vec_t   weight_i,
    input  data_vec_t   line_i,
    output prod_stage_t prod_o
);

    localparam int PROD_W = $bits(prod_t);

    prod_vec_t prod_d;
    prod_vec_t prod_q;
    logic      valid_q;

    always_comb begin
        for (int i = 0; i < VEC_LEN; i++) begin
            prod_d[i*PROD_W +: PROD_W] = prod_t'(weight_i[i*DATA_W +: DATA_W])
                                       * prod_t'(line_i[i*DATA_W +: DATA_W]);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= compute_i;
        end
    end

    always_ff @(posedge clk) begin
        if (compute_i) begin
            prod_q <= prod_d;   // Held between runs
        end
    end

    assign prod_o = '{valid: valid_q, prod: prod_q};

endmodule

// File: source/adder_tree.sv
`timescale 1ns/1ps
/*
 * Adder tree
 * Reduces low and high product bytes of each vector half into four byte sums
 */
module adder_tree
    import cnn_types_pkg::*;
    import cnn_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  prod_stage_t prod_i,
    output psum_stage_t psum_o
);

    localparam int PROD_W = $bits(prod_t);
    localparam int HALVES = VEC_LEN / GROUP_LEN;    // Groups per byte lane

    psum_vec_t psum_d;
    psum_vec_t psum_q;
    logic      valid_q;

    // Pairwise reduction of one group, all adds modulo 256
    function automatic data_t group_sum(prod_vec_t prods, int base, logic high);
        data_t part [GROUP_LEN];
        for (int i = 0; i < GROUP_LEN; i++) begin
            part[i] = prods[(base + i) * PROD_W + (high ? DATA_W : 0) +: DATA_W];
        end
        // Each level folds neighbours into the lower slots
        for (int w = GROUP_LEN / 2; w > 0; w = w / 2) begin
            for (int i = 0; i < w; i++) begin
                part[i] = part[2*i] + part[2*i+1];
            end
        end
        return part[0];
    endfunction

    always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
            // Low bytes first, then high bytes, each over both halves
            psum_d[g*DATA_W +: DATA_W] = group_sum(prod_i.prod,
                                                   (g % HALVES) * GROUP_LEN,
                                                   (g / HALVES) != 0);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= prod_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (prod_i.valid) begin
            psum_q <= psum_d;
        end
    end

    assign psum_o = '{valid: valid_q, psum: psum_q};

endmodule

// File: source/result_serializer.sv
`timescale 1ns/1ps
/*
 * Result serializer
 * Captures the partial sums and streams NUM_RESULTS bytes, byte k = sum (k mod 4)
 */
module result_serializer
    import cnn_types_pkg::*;
    import cnn_ctrl_pkg::*;
#(
    parameter int NUM_RESULTS = DEFAULT_NUM_RESULTS
) (
    input  logic         clk,
    input  logic         reset,
    input  psum_stage_t  psum_i,
    output byte_stream_t result_o
);

    localparam int CNT_W = (NUM_RESULTS > 1) ? $clog2(NUM_RESULTS) : 1;

    ser_state_t       state_q;
    logic [CNT_W-1:0] cnt_q;     // Index k of the byte on result_o
    psum_vec_t        cap_q;
    logic             last_byte;

    assign last_byte = (cnt_q == CNT_W'(NUM_RESULTS - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= SER_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                SER_IDLE: begin
                    if (psum_i.valid) begin
                        state_q <= SER_EMIT;
                        cnt_q   <= '0;
                    end
                end
                SER_EMIT: begin
                    if (psum_i.valid) begin
                        cnt_q <= '0;            // New sums restart the stream
                    end else if (last_byte) begin
                        state_q <= SER_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (psum_i.valid) begin
            cap_q <= psum_i.psum;
        end
    end

    // Valid from the cycle after done, one byte per cycle
    assign result_o = '{
        valid: (state_q == SER_EMIT),
        data:  cap_q[(int'(cnt_q) % NUM_GROUPS) * DATA_W +: DATA_W]
    };

endmodule

// File: source/cnn_accel_top.sv
`timescale 1ns/1ps
/*
 * CNN dot-product engine top level
 * Load side, multiplier and adder pipeline, result serializer
 */
module cnn_accel_top
    import cnn_types_pkg::*;
    import cnn_ctrl_pkg::*;
#(
    parameter int NUM_RESULTS = DEFAULT_NUM_RESULTS
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         start_i,
    input  byte_stream_t weight_in_i,
    input  byte_stream_t line_in_i,
    output byte_stream_t result_o,
    output logic         done_o
);

    buf_write_t  weight_wr;
    buf_write_t  line_wr;
    logic        compute;
    data_vec_t   weight_vec;
    data_vec_t   line_vec;
    prod_stage_t prod;
    psum_stage_t psum;

    // Input side
    load_controller load_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .start_i     (start_i),
        .weight_in_i (weight_in_i),
        .line_in_i   (line_in_i),
        .weight_wr_o (weight_wr),
        .line_wr_o   (line_wr),
        .compute_o   (compute)
    );

    operand_buffer weight_buf_i (
        .clk    (clk),
        .reset  (reset),
        .wr_i   (weight_wr),
        .data_o (weight_vec)
    );

    operand_buffer line_buf_i (
        .clk    (clk),
        .reset  (reset),
        .wr_i   (line_wr),
        .data_o (line_vec)
    );

    // Processing, two register stages
    mac_array mac_array_i (
        .clk       (clk),
        .reset     (reset),
        .compute_i (compute),
        .weight_i  (weight_vec),
        .line_i    (line_vec),
        .prod_o    (prod)
    );

    adder_tree adder_tree_i (
        .clk    (clk),
        .reset  (reset),
        .prod_i (prod),
        .psum_o (psum)
    );

    assign done_o = psum.valid;     // Sums ready

    // Output side
    result_serializer #(
        .NUM_RESULTS (NUM_RESULTS)
    ) result_ser_i (
        .clk      (clk),
        .reset    (reset),
        .psum_i   (psum),
        .result_o (result_o)
    );

endmodule

// File: tests/cnn_accel_model.svh
/*
 * Reference model of the CNN dot-product engine
 * Partial sums and result bytes from the operand vectors and the value compare
 */
`ifndef CNN_ACCEL_MODEL_SVH
`define CNN_ACCEL_MODEL_SVH

// Sum g over one vector half with low product bytes for g0/g1 and high bytes for g2/g3
function automatic int expected_psum(input data_vec_t w, input data_vec_t l, input int g);
    int first;
    int sum;
    int p;
    first = (g % 2) * GROUP_LEN;    // Odd groups take elements 8-15
    sum   = 0;
    for (int i = first; i < first + GROUP_LEN; i++) begin
        p   = int'(w[i*DATA_W +: DATA_W]) * int'(l[i*DATA_W +: DATA_W]);
        sum = (sum + ((g < 2) ? (p % 256) : (p / 256))) % 256;
    end
    return sum;
endfunction

// Byte k of the result stream repeats the four sums
function automatic int expected_result(input data_vec_t w, input data_vec_t l, input int k);
    return expected_psum(w, l, k % 4);
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("FAIL at %0d ns: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
        report_failure();
    end
endtask

`endif

// File: tests/cnn_accel_tb.sv
`timescale 1ns/1ps
/*
 * Testbench of the CNN dot-product engine
 * Random operand loads with gaps and stray bytes checked against the model
 */
module cnn_accel_tb
    import cnn_types_pkg::*;
    import cnn_ctrl_pkg::*;
();

    localparam int NUM_RES      = 16;
    localparam int DONE_LATENCY = 4;    // Sampled cycles from the accepting edge to done_o
    localparam int DONE_TIMEOUT = 40;

    logic         clk;
    logic         reset;
    logic         start;
    byte_stream_t weight_in;
    byte_stream_t line_in;
    byte_stream_t result;
    logic         done;

    integer    seed;
    data_vec_t weights;     // Operands of the current run
    data_vec_t lines;

    `include "cnn_accel_model.svh"

    cnn_accel_top #(
        .NUM_RESULTS (NUM_RES)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .start_i     (start),
        .weight_in_i (weight_in),
        .line_in_i   (line_in),
        .result_o    (result),
        .done_o      (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    // done_o and the result strobe must stay low while nothing is pending
    task automatic check_idle(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            check_value("done_o", 0, done);
            check_value("result_o.valid", 0, result.valid);
        end
    endtask

    // One operand vector on its stream with junk on the other stream in gaps when stray
    task automatic send_operands(input logic is_line, input data_vec_t vec,
                                 input logic gaps, input logic stray);
        int idle;
        for (int i = 0; i < VEC_LEN; i++) begin
            idle = gaps ? ($unsigned($random(seed)) % 4) : 0;
            if (stray && i == 8 && idle == 0) begin
                idle = 1;   // Room for the mid-load start
            end
            for (int c = 0; c < idle; c++) begin
                @(posedge clk);
                weight_in <= '{valid: stray && is_line, data: data_t'($random(seed))};
                line_in   <= '{valid: stray && !is_line, data: data_t'($random(seed))};
                start     <= stray && (i == 8) && (c == 0);
            end
            @(posedge clk);
            start     <= 1'b0;
            weight_in <= '{valid: !is_line, data: vec[i*DATA_W +: DATA_W]};
            line_in   <= '{valid: is_line, data: vec[i*DATA_W +: DATA_W]};
        end
    endtask

    task automatic run_once(input logic new_data, input logic gaps, input logic stray);
        int wait_cnt;
        if (new_data) begin
            for (int i = 0; i < VEC_LEN; i++) begin
                weights[i*DATA_W +: DATA_W] = data_t'($random(seed));
                lines[i*DATA_W +: DATA_W]   = data_t'($random(seed));
            end
        end
        @(posedge clk);
        start <= 1'b1;
        send_operands(1'b0, weights, gaps, stray);
        send_operands(1'b1, lines, gaps, stray);
        @(posedge clk);     // This edge accepts the last line byte
        weight_in <= '{valid: 1'b0, data: '0};
        line_in   <= '{valid: 1'b0, data: '0};
        wait_cnt = 1;
        @(negedge clk);
        while (done !== 1'b1) begin
            if (wait_cnt == DONE_TIMEOUT) begin
                $display("Timeout: done_o never rose after the last line byte");
                report_failure();
            end
            @(negedge clk);
            wait_cnt++;
        end
        check_value("done_o latency", DONE_LATENCY, wait_cnt);
        for (int k = 0; k < NUM_RES; k++) begin
            @(negedge clk);
            check_value("done_o", 0, done);     // Single pulse
            check_value("result_o.valid", 1, result.valid);
            check_value("result_o.data", expected_result(weights, lines, k), result.data);
        end
        check_idle(1);
    endtask

    initial begin
        seed        = 67;
        reset       = 1'b1;
        start       = 1'b0;
        weight_in   = '0;
        line_in     = '0;
        weights     = '0;
        lines       = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        check_idle(20);
        run_once(1'b1, 1'b0, 1'b0);     // Back-to-back bytes
        check_idle(3);
        run_once(1'b0, 1'b1, 1'b0);     // Same data with gaps
        check_idle(2);
        run_once(1'b1, 1'b1, 1'b1);     // Stray bytes and a mid-load start
        for (int r = 0; r < 5; r++) begin
            check_idle(1 + ($unsigned($random(seed)) % 4));
            run_once(1'b1, 1'b1, r[0]);
        end
        check_idle(10);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: list.f
+incdir+tests
source/cnn_types_pkg.sv
source/cnn_ctrl_pkg.sv
source/load_controller.sv
source/operand_buffer.sv
source/mac_array.sv
source/adder_tree.sv
source/result_serializer.sv
source/cnn_accel_top.sv
tests/cnn_accel_tb.sv

// File: Bender.yml
package:
  name: cnn_accel

sources:
  # Packages first, then the RTL bottom up
  - source/cnn_types_pkg.sv
  - source/cnn_ctrl_pkg.sv
  - source/load_controller.sv
  - source/operand_buffer.sv
  - source/mac_array.sv
  - source/adder_tree.sv
  - source/result_serializer.sv
  - source/cnn_accel_top.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/cnn_accel_tb.sv
